// File: flist.f
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/cpu_alu.sv
hdl/cpu_datapath.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
sim/cpu_assert.sv
sim/cpu_tb.sv

// File: hdl/cpu_alu.sv
`default_nettype none

module cpu_alu (
	input wire cpu_pkg::word_t a,
	input wire cpu_pkg::word_t b,
	input wire cpu_pkg::alufunc_t func,
	output cpu_pkg::word_t result,
	output cpu_pkg::ccr_t ccr_out
);

	logic [4:0] shamt;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b[4:0];

	always_comb
	begin
		case (func)
			cpu_pkg::alu_add: result = a + b;
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or: result = a | b;
			cpu_pkg::alu_xor: result = a ^ b;
			cpu_pkg::alu_shl: result = a << shamt;
			cpu_pkg::alu_shr: result = a >> shamt;
			cpu_pkg::alu_asr: result = cpu_pkg::word_t'($signed(a) >>> shamt);
			default: result = a + b;
		endcase
	end

	// flags come from the compare regardless of func
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);
	assign ccr_out = {ltu, lt, eq};

endmodule

`default_nettype wire

// File: hdl/cpu_control.sv
`default_nettype none

module cpu_control (
	input wire clk_i,
	input wire rst_i,
	input wire cpu_pkg::word_t ir,
	input wire cpu_pkg::ccr_t ccr,
	input wire ins_ack,
	input wire dat_ack,
	input wire dat_stall,
	output cpu_pkg::ctl_t ctl,
	output logic ins_cyc,
	output logic ins_stb,
	output logic dat_cyc,
	output logic dat_stb,
	output logic dat_we,
	output logic halt
);

	localparam logic [3:0] op_nop = 4'h0;

	cpu_pkg::itype_t ir_type;
	logic [3:0] ir_op;
	cpu_pkg::reg_addr_t ir_ra;
	cpu_pkg::reg_addr_t ir_rb;
	cpu_pkg::reg_addr_t ir_rc;
	logic ir_size;
	logic ccr_ltu;
	logic ccr_lt;
	logic ccr_eq;
	logic take_branch;
	cpu_pkg::state_t state;
	cpu_pkg::state_t state_next;
	logic ins_cyc_next;
	logic ins_stb_next;
	logic dat_cyc_next;
	logic dat_stb_next;
	logic dat_we_next;

	assign ir_type = cpu_pkg::itype_t'(ir[31:28]);
	assign ir_op = ir[27:24];
	assign ir_ra = ir[23:20];
	assign ir_rb = ir[19:16];
	assign ir_rc = ir[15:12];
	assign ir_size = ir[0];
	assign {ccr_ltu, ccr_lt, ccr_eq} = ccr;
	assign halt = (state == cpu_pkg::s_halt);

	always_comb
	begin
		case (ir_op)
			4'h0: take_branch = 1'b1; // bra
			4'h1: take_branch = ccr_eq; // beq
			4'h2: take_branch = ~ccr_eq; // bne
			4'h3: take_branch = ~(ccr_ltu | ccr_eq); // bgtu
			4'h4: take_branch = ~(ccr_lt | ccr_eq); // bgt
			4'h5: take_branch = ~ccr_lt; // bge
			4'h6: take_branch = ccr_lt | ccr_eq; // ble
			4'h7: take_branch = ccr_lt; // blt
			4'h8: take_branch = ~ccr_ltu; // bgeu
			4'h9: take_branch = ccr_ltu; // bltu
			4'ha: take_branch = ccr_ltu | ccr_eq; // bleu
			default: take_branch = 1'b0; // brn
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= cpu_pkg::s_reset;
			ins_cyc <= 1'b0;
			ins_stb <= 1'b0;
			dat_cyc <= 1'b0;
			dat_stb <= 1'b0;
			dat_we <= 1'b0;
		end
		else
		begin
			state <= state_next;
			ins_cyc <= ins_cyc_next;
			ins_stb <= ins_stb_next;
			dat_cyc <= dat_cyc_next;
			dat_stb <= dat_stb_next;
			dat_we <= dat_we_next;
		end
	end

	always_comb
	begin
		state_next = state;
		ins_cyc_next = ins_cyc;
		ins_stb_next = ins_stb;
		dat_cyc_next = dat_cyc;
		dat_stb_next = dat_stb;
		dat_we_next = dat_we;
		ctl.ir_write = 1'b0;
		ctl.a_write = 1'b0;
		ctl.b_write = 1'b0;
		ctl.reg_write = 1'b0;
		ctl.reg_read_addr1 = ir_ra;
		ctl.reg_read_addr2 = ir_rb;
		ctl.reg_write_addr = ir_ra;
		ctl.alu_func = cpu_pkg::alu_add;
		ctl.alu2sel = cpu_pkg::alu_b;
		ctl.regsel = cpu_pkg::reg_alu;
		ctl.mdrsel = cpu_pkg::mdr_hold;
		ctl.marsel = cpu_pkg::mar_hold;
		ctl.pcsel = cpu_pkg::pc_hold;
		ctl.ccr_write = 1'b0;

		case (state)
			cpu_pkg::s_reset: state_next = cpu_pkg::s_fetch;
			cpu_pkg::s_fetch:
			begin
				ins_cyc_next = 1'b1;
				ins_stb_next = 1'b1;
				state_next = cpu_pkg::s_fetch2;
			end
			cpu_pkg::s_fetch2:
			begin
				ins_stb_next = 1'b0;
				if (ins_ack)
				begin
					ctl.ir_write = 1'b1;
					ctl.pcsel = cpu_pkg::pc_next;
					ins_cyc_next = 1'b0;
					state_next = cpu_pkg::s_eval;
				end
			end
			cpu_pkg::s_eval:
			begin
				ctl.a_write = 1'b1; // A <= rA
				ctl.b_write = 1'b1; // B <= rB
				if (ir_size)
					state_next = cpu_pkg::s_halt; // no extended forms
				else
				begin
					case (ir_type)
						cpu_pkg::t_inh:
							state_next = (ir_op == op_nop) ? cpu_pkg::s_inh : cpu_pkg::s_halt;
						cpu_pkg::t_cmp: state_next = cpu_pkg::s_cmp;
						cpu_pkg::t_alu: state_next = cpu_pkg::s_alu;
						cpu_pkg::t_ldi: state_next = cpu_pkg::s_ldiu;
						cpu_pkg::t_load: state_next = cpu_pkg::s_load;
						cpu_pkg::t_store: state_next = cpu_pkg::s_store;
						cpu_pkg::t_branch: state_next = cpu_pkg::s_branch;
						default: state_next = cpu_pkg::s_halt;
					endcase
				end
			end
			cpu_pkg::s_inh: state_next = cpu_pkg::s_fetch; // nop
			cpu_pkg::s_cmp:
			begin
				ctl.alu_func = cpu_pkg::alu_sub;
				state_next = cpu_pkg::s_cmp2;
			end
			cpu_pkg::s_cmp2:
			begin
				ctl.alu_func = cpu_pkg::alu_sub;
				ctl.ccr_write = 1'b1;
				state_next = cpu_pkg::s_fetch;
			end
			cpu_pkg::s_alu:
			begin
				ctl.reg_read_addr1 = ir_rb;
				ctl.reg_read_addr2 = ir_rc;
				ctl.a_write = 1'b1; // A <= rB
				ctl.b_write = 1'b1; // B <= rC
				state_next = ir_op[3] ? cpu_pkg::s_alu3 : cpu_pkg::s_alu2;
			end
			cpu_pkg::s_alu2:
			begin
				ctl.alu_func = cpu_pkg::alufunc_t'(ir_op[2:0]);
				state_next = cpu_pkg::s_alu4;
			end
			cpu_pkg::s_alu3:
			begin
				ctl.alu_func = cpu_pkg::alufunc_t'(ir_op[2:0]);
				ctl.alu2sel = cpu_pkg::alu_sval;
				state_next = cpu_pkg::s_alu4;
			end
			cpu_pkg::s_alu4:
			begin
				ctl.alu_func = cpu_pkg::alufunc_t'(ir_op[2:0]);
				ctl.alu2sel = ir_op[3] ? cpu_pkg::alu_sval : cpu_pkg::alu_b;
				ctl.mdrsel = cpu_pkg::mdr_alu;
				state_next = cpu_pkg::s_mdr2ra;
			end
			cpu_pkg::s_mdr2ra:
			begin
				ctl.regsel = cpu_pkg::reg_mdr; // rA <= MDR
				ctl.reg_write = 1'b1;
				state_next = cpu_pkg::s_term;
			end
			cpu_pkg::s_ldiu:
			begin
				ctl.regsel = cpu_pkg::reg_uval;
				ctl.reg_write = 1'b1;
				state_next = cpu_pkg::s_fetch;
			end
			cpu_pkg::s_branch:
			begin
				if (take_branch)
					ctl.pcsel = cpu_pkg::pc_rel;
				state_next = cpu_pkg::s_fetch;
			end
			cpu_pkg::s_load:
			begin
				ctl.reg_read_addr1 = ir_rb;
				ctl.a_write = 1'b1;
				state_next = cpu_pkg::s_load2;
			end
			cpu_pkg::s_load2:
			begin
				ctl.alu2sel = cpu_pkg::alu_sval;
				state_next = cpu_pkg::s_load3;
			end
			cpu_pkg::s_load3:
			begin
				ctl.alu2sel = cpu_pkg::alu_sval;
				ctl.marsel = cpu_pkg::mar_alu; // MAR <= rB + sval
				state_next = cpu_pkg::s_loadd2;
			end
			cpu_pkg::s_loadd2:
			begin
				if (!dat_stall)
				begin
					dat_cyc_next = 1'b1;
					dat_stb_next = 1'b1;
					state_next = cpu_pkg::s_loadd3;
				end
			end
			cpu_pkg::s_loadd3:
			begin
				dat_stb_next = 1'b0;
				if (dat_ack)
				begin
					ctl.mdrsel = cpu_pkg::mdr_dbus;
					dat_cyc_next = 1'b0;
					state_next = cpu_pkg::s_mdr2ra;
				end
			end
			cpu_pkg::s_store:
			begin
				ctl.reg_read_addr1 = ir_rb;
				ctl.a_write = 1'b1;
				state_next = cpu_pkg::s_store2;
			end
			cpu_pkg::s_store2:
			begin
				ctl.alu2sel = cpu_pkg::alu_sval;
				ctl.marsel = cpu_pkg::mar_alu;
				ctl.a_write = 1'b1; // A <= rA, same edge as MAR
				state_next = cpu_pkg::s_store3;
			end
			cpu_pkg::s_store3:
			begin
				ctl.mdrsel = cpu_pkg::mdr_a;
				state_next = cpu_pkg::s_store4;
			end
			cpu_pkg::s_store4:
			begin
				if (!dat_stall)
				begin
					dat_cyc_next = 1'b1;
					dat_stb_next = 1'b1;
					dat_we_next = 1'b1;
					state_next = cpu_pkg::s_store5;
				end
			end
			cpu_pkg::s_store5:
			begin
				dat_stb_next = 1'b0;
				if (dat_ack)
				begin
					dat_cyc_next = 1'b0;
					dat_we_next = 1'b0;
					state_next = cpu_pkg::s_term;
				end
			end
			cpu_pkg::s_term: state_next = cpu_pkg::s_fetch;
			cpu_pkg::s_halt: state_next = cpu_pkg::s_halt; // until reset
			default: state_next = cpu_pkg::s_halt;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cpu_datapath.sv
`default_nettype none

module cpu_datapath #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input wire clk_i,
	input wire rst_i,
	input wire cpu_pkg::ctl_t ctl,
	input wire cpu_pkg::word_t ins_rdata,
	input wire cpu_pkg::word_t dat_rdata,
	output cpu_pkg::word_t ir,
	output cpu_pkg::ccr_t ccr,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t mar,
	output cpu_pkg::word_t mdr
);

	cpu_pkg::word_t a_q;
	cpu_pkg::word_t b_q;
	cpu_pkg::word_t sval;
	cpu_pkg::word_t uval;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t reg_wdata;
	cpu_pkg::word_t rdata1;
	cpu_pkg::word_t rdata2;
	cpu_pkg::ccr_t alu_ccr;

	assign sval = {{17{ir[15]}}, ir[15:1]};
	assign uval = {17'h0, ir[15:1]};
	assign alu_b = (ctl.alu2sel == cpu_pkg::alu_sval) ? sval : b_q;

	always_comb
	begin
		case (ctl.regsel)
			cpu_pkg::reg_mdr: reg_wdata = mdr;
			cpu_pkg::reg_uval: reg_wdata = uval;
			default: reg_wdata = alu_result;
		endcase
	end

	reg_file u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.read_addr1(ctl.reg_read_addr1),
		.read_addr2(ctl.reg_read_addr2),
		.write_addr(ctl.reg_write_addr),
		.write_en(ctl.reg_write),
		.write_data(reg_wdata),
		.read_data1(rdata1),
		.read_data2(rdata2)
	);

	cpu_alu u_alu (
		.a(a_q),
		.b(alu_b),
		.func(ctl.alu_func),
		.result(alu_result),
		.ccr_out(alu_ccr)
	);

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pc <= RESET_PC;
			ccr <= '0;
		end
		else
		begin
			if (ctl.pcsel == cpu_pkg::pc_next)
				pc <= pc + 32'd4;
			else if (ctl.pcsel == cpu_pkg::pc_rel)
				pc <= pc + (sval << 2); // pc already points past the branch
			if (ctl.ccr_write)
				ccr <= alu_ccr;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (ctl.ir_write)
			ir <= ins_rdata;
		if (ctl.a_write)
			a_q <= rdata1;
		if (ctl.b_write)
			b_q <= rdata2;
		if (ctl.marsel == cpu_pkg::mar_alu)
			mar <= alu_result;
		case (ctl.mdrsel)
			cpu_pkg::mdr_alu: mdr <= alu_result;
			cpu_pkg::mdr_dbus: mdr <= dat_rdata;
			cpu_pkg::mdr_a: mdr <= a_q; // store data
			default: mdr <= mdr;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 4;
	localparam int num_regs = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [2:0] ccr_t; // {ltu, lt, eq}

	typedef enum logic [4:0] {
		s_reset, s_fetch, s_fetch2, s_eval, s_inh,
		s_cmp, s_cmp2, s_alu, s_alu2, s_alu3, s_alu4,
		s_mdr2ra, s_ldiu, s_branch,
		s_load, s_load2, s_load3, s_loadd2, s_loadd3,
		s_store, s_store2, s_store3, s_store4, s_store5,
		s_term, s_halt
	} state_t;

	// instruction type field, ir[31:28]
	typedef enum logic [3:0] {
		t_inh = 4'd0,
		t_cmp = 4'd3,
		t_alu = 4'd7,
		t_ldi = 4'd8,
		t_load = 4'd9,
		t_store = 4'd10,
		t_branch = 4'd11
	} itype_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or,
		alu_xor, alu_shl, alu_shr, alu_asr
	} alufunc_t;

	typedef enum logic {alu_b, alu_sval} alu_in_t;
	typedef enum logic [1:0] {reg_alu, reg_mdr, reg_uval} reg_in_t;
	typedef enum logic [1:0] {mdr_hold, mdr_alu, mdr_dbus, mdr_a} mdr_in_t;
	typedef enum logic {mar_hold, mar_alu} mar_in_t;
	typedef enum logic [1:0] {pc_hold, pc_next, pc_rel} pc_in_t;

	typedef struct packed {
		logic ir_write;
		logic a_write;
		logic b_write;
		logic reg_write;
		reg_addr_t reg_read_addr1;
		reg_addr_t reg_read_addr2;
		reg_addr_t reg_write_addr;
		alufunc_t alu_func;
		alu_in_t alu2sel;
		reg_in_t regsel;
		mdr_in_t mdrsel;
		mar_in_t marsel;
		pc_in_t pcsel;
		logic ccr_write;
	} ctl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		word_t adr;
	} ins_req_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t wdata;
	} dat_req_t;

	typedef struct packed {
		logic ack;
		word_t rdata;
	} ins_rsp_t;

	typedef struct packed {
		logic ack;
		logic stall;
		word_t rdata;
	} dat_rsp_t;

endpackage

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input wire clk_i,
	input wire rst_i,
	output cpu_pkg::ins_req_t ins_req,
	input wire cpu_pkg::ins_rsp_t ins_rsp,
	output cpu_pkg::dat_req_t dat_req,
	input wire cpu_pkg::dat_rsp_t dat_rsp,
	output logic halt
);

	cpu_pkg::ctl_t ctl;
	cpu_pkg::word_t ir;
	cpu_pkg::word_t pc;
	cpu_pkg::word_t mar;
	cpu_pkg::word_t mdr;
	cpu_pkg::ccr_t ccr;
	logic ins_cyc;
	logic ins_stb;
	logic dat_cyc;
	logic dat_stb;
	logic dat_we;

	cpu_control u_control (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ir(ir),
		.ccr(ccr),
		.ins_ack(ins_rsp.ack),
		.dat_ack(dat_rsp.ack),
		.dat_stall(dat_rsp.stall),
		.ctl(ctl),
		.ins_cyc(ins_cyc),
		.ins_stb(ins_stb),
		.dat_cyc(dat_cyc),
		.dat_stb(dat_stb),
		.dat_we(dat_we),
		.halt(halt)
	);

	cpu_datapath #(
		.RESET_PC(RESET_PC)
	) u_datapath (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ctl(ctl),
		.ins_rdata(ins_rsp.rdata),
		.dat_rdata(dat_rsp.rdata),
		.ir(ir),
		.ccr(ccr),
		.pc(pc),
		.mar(mar),
		.mdr(mdr)
	);

	assign ins_req.cyc = ins_cyc;
	assign ins_req.stb = ins_stb;
	assign ins_req.adr = pc;

	assign dat_req.cyc = dat_cyc;
	assign dat_req.stb = dat_stb;
	assign dat_req.we = dat_we;
	assign dat_req.adr = mar;
	assign dat_req.wdata = mdr;

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file (
	input wire clk_i,
	input wire rst_i,
	input wire cpu_pkg::reg_addr_t read_addr1,
	input wire cpu_pkg::reg_addr_t read_addr2,
	input wire cpu_pkg::reg_addr_t write_addr,
	input wire write_en,
	input wire cpu_pkg::word_t write_data,
	output cpu_pkg::word_t read_data1,
	output cpu_pkg::word_t read_data2
);

	cpu_pkg::word_t regs [cpu_pkg::num_regs];

	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < cpu_pkg::num_regs; i++)
				regs[i] <= '0;
		end
		else if (write_en)
			regs[write_addr] <= write_data;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f flist.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vcpu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi
echo "$out" | grep -q "All tests passed" || exit 1
exit 0

// File: sim/cpu_assert.sv
`default_nettype none

module cpu_assert (
	input wire clk_i,
	input wire rst_i,
	input wire cpu_pkg::ins_req_t ins_req,
	input wire cpu_pkg::dat_req_t dat_req,
	input wire halt
);

	stb_in_ins_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		ins_req.stb |-> ins_req.cyc) else $error("instruction stb without cyc");

	stb_in_dat_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		dat_req.stb |-> dat_req.cyc) else $error("data stb without cyc");

	one_bus_at_a_time: assert property (@(posedge clk_i) disable iff (rst_i)
		!(ins_req.cyc && dat_req.cyc)) else $error("both bus cycles open");

	quiet_in_halt: assert property (@(posedge clk_i) disable iff (rst_i)
		halt |-> !ins_req.cyc && !dat_req.cyc) else $error("bus cycle while halted");

	halt_sticks: assert property (@(posedge clk_i) disable iff (rst_i)
		halt |=> halt) else $error("halt fell without reset");

endmodule

bind cpu_top cpu_assert u_assert (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.ins_req(ins_req),
	.dat_req(dat_req),
	.halt(halt)
);

`default_nettype wire

// File: sim/cpu_tb.sv
`default_nettype none

module cpu_tb;

	logic clk_i;
	logic rst_i;
	cpu_pkg::ins_req_t ins_req;
	cpu_pkg::ins_rsp_t ins_rsp;
	cpu_pkg::dat_req_t dat_req;
	cpu_pkg::dat_rsp_t dat_rsp;
	logic halt;

	cpu_pkg::word_t imem [256];
	cpu_pkg::word_t dmem [256];
	logic [31:0] lfsr;
	logic [2:0] ins_cnt;
	logic [2:0] dat_cnt;
	int prog_pc;
	int errors;
	int checks;

	cpu_top dut (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ins_req(ins_req),
		.ins_rsp(ins_rsp),
		.dat_req(dat_req),
		.dat_rsp(dat_rsp),
		.halt(halt)
	);

	always #50 clk_i = ~clk_i;

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// instruction and data bus slaves
	always @(posedge clk_i)
	begin
		ins_rsp.ack <= 1'b0;
		dat_rsp.ack <= 1'b0;
		dat_rsp.stall <= (rand_bits(2) == 32'd0); // stall about one cycle in four
		if (rst_i)
		begin
			ins_cnt <= '0;
			dat_cnt <= '0;
		end
		else
		begin
			if (ins_req.cyc && ins_req.stb)
				ins_cnt <= 3'(rand_bits(2)) + 3'd1;
			else if (ins_cnt != 3'd0)
			begin
				ins_cnt <= ins_cnt - 3'd1;
				if (ins_cnt == 3'd1)
				begin
					ins_rsp.ack <= 1'b1;
					ins_rsp.rdata <= imem[ins_req.adr[9:2]];
				end
			end
			if (dat_req.cyc && dat_req.stb)
				dat_cnt <= 3'(rand_bits(2)) + 3'd1;
			else if (dat_cnt != 3'd0)
			begin
				dat_cnt <= dat_cnt - 3'd1;
				if (dat_cnt == 3'd1)
				begin
					dat_rsp.ack <= 1'b1;
					dat_rsp.rdata <= dmem[dat_req.adr[9:2]];
					if (dat_req.we)
						dmem[dat_req.adr[9:2]] = dat_req.wdata;
				end
			end
		end
	end

	function automatic cpu_pkg::word_t enc(input logic [3:0] t, input logic [3:0] op,
		input logic [3:0] ra, input logic [3:0] rb, input logic [14:0] imm);
		return {t, op, ra, rb, imm, 1'b0};
	endfunction

	// expected alu result
	function automatic cpu_pkg::word_t model_alu(input int f, input cpu_pkg::word_t a,
		input cpu_pkg::word_t b);
		case (f)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			6: return a >> b[4:0];
			default: return cpu_pkg::word_t'($signed(a) >>> b[4:0]);
		endcase
	endfunction

	function automatic logic branch_taken(input int op, input cpu_pkg::word_t a,
		input cpu_pkg::word_t b);
		logic eq;
		logic lt;
		logic ltu;
		eq = (a == b);
		lt = ($signed(a) < $signed(b));
		ltu = (a < b);
		case (op)
			0: return 1'b1;
			1: return eq;
			2: return !eq;
			3: return !ltu && !eq; // a > b unsigned
			4: return !lt && !eq;
			5: return !lt;
			6: return lt || eq;
			7: return lt;
			8: return !ltu;
			9: return ltu;
			10: return ltu || eq;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		checks++;
		if (exp !== act)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic clear_mems();
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = enc(4'h0, 4'h4, 4'h0, 4'h0, 15'h0); // halt
			dmem[i] = '0;
		end
		prog_pc = 0;
	endtask

	task automatic emit(input cpu_pkg::word_t w);
		imem[prog_pc] = w;
		prog_pc++;
	endtask

	// reset, first fetch from address 0, then wait for halt
	task automatic run_program(input string name);
		int n;
		@(posedge clk_i);
		rst_i <= 1'b1;
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		check_bit({name, " ins cyc in reset"}, 1'b0, ins_req.cyc);
		check_bit({name, " ins stb in reset"}, 1'b0, ins_req.stb);
		check_bit({name, " dat cyc in reset"}, 1'b0, dat_req.cyc);
		check_bit({name, " dat stb in reset"}, 1'b0, dat_req.stb);
		check_bit({name, " dat we in reset"}, 1'b0, dat_req.we);
		check_bit({name, " halt in reset"}, 1'b0, halt);
		@(posedge clk_i);
		rst_i <= 1'b0;
		n = 0;
		while (!ins_req.cyc && n < 10)
		begin
			@(negedge clk_i);
			n++;
		end
		if (!ins_req.cyc)
		begin
			$display("%s: no instruction fetch after reset", name);
			errors++;
		end
		check_word({name, " first fetch address"}, '0, ins_req.adr);
		n = 0;
		while (!halt && n < 4000)
		begin
			@(negedge clk_i);
			n++;
		end
		if (!halt)
		begin
			$display("%s: core did not halt within 4000 cycles", name);
			errors++;
		end
	endtask

	task automatic alu_reg_ops();
		cpu_pkg::word_t a;
		clear_mems();
		emit(enc(4'h8, 4'h0, 4'd1, 4'd0, 15'h6a5c));
		emit(enc(4'h8, 4'h0, 4'd2, 4'd0, 15'd5));
		emit(enc(4'h7, 4'h1, 4'd1, 4'd0, {4'd1, 11'h0})); // r1 = r0 - r1
		for (int f = 0; f < 8; f++)
		begin
			emit(enc(4'h7, 4'(f), 4'd3, 4'd1, {4'd2, 11'h0}));
			emit(enc(4'ha, 4'h0, 4'd3, 4'd0, 15'(4 * f)));
		end
		run_program("alu_rr");
		a = 32'd0 - 32'h6a5c;
		for (int f = 0; f < 8; f++)
			check_word($sformatf("alu_rr func %0d", f), model_alu(f, a, 32'd5), dmem[f]);
	endtask

	task automatic imm_load_store();
		cpu_pkg::word_t dval;
		cpu_pkg::word_t e6;
		clear_mems();
		dval = rand_bits(32);
		dmem[10] = dval;
		emit(enc(4'h8, 4'h0, 4'd5, 4'd0, 15'h20));
		emit(enc(4'h9, 4'h0, 4'd6, 4'd5, 15'd8)); // word 10
		emit(enc(4'h7, 4'h8, 4'd6, 4'd6, 15'(-3)));
		emit(enc(4'h7, 4'hc, 4'd7, 4'd6, 15'h4123)); // negative sval
		emit(enc(4'ha, 4'h0, 4'd7, 4'd5, 15'(-4))); // word 7
		emit(enc(4'ha, 4'h0, 4'd6, 4'd5, 15'd12)); // word 11
		run_program("imm_mem");
		e6 = dval - 32'd3;
		check_word("imm_mem add", e6, dmem[11]);
		check_word("imm_mem xor", e6 ^ 32'hffffc123, dmem[7]);
	endtask

	task automatic branch_table();
		cpu_pkg::word_t va [3];
		cpu_pkg::word_t vb [3];
		logic taken;
		va = '{32'd5, 32'hfffffffd, 32'd4};
		vb = '{32'd5, 32'd4, 32'hfffffffd};
		for (int p = 0; p < 3; p++)
		begin
			for (int op = 0; op < 12; op++)
			begin
				clear_mems();
				dmem[8] = va[p];
				dmem[9] = vb[p];
				emit(enc(4'h9, 4'h0, 4'd1, 4'd0, 15'd32));
				emit(enc(4'h9, 4'h0, 4'd2, 4'd0, 15'd36));
				emit(enc(4'h8, 4'h0, 4'd3, 4'd0, 15'd1));
				emit(enc(4'h8, 4'h0, 4'd4, 4'd0, 15'd2));
				emit(enc(4'h3, 4'h0, 4'd1, 4'd2, 15'h0));
				emit(enc(4'hb, 4'(op), 4'd0, 4'd0, 15'd2)); // skips two words
				emit(enc(4'ha, 4'h0, 4'd3, 4'd0, 15'd0));
				emit(enc(4'h0, 4'h4, 4'd0, 4'd0, 15'h0));
				emit(enc(4'ha, 4'h0, 4'd4, 4'd0, 15'd4));
				run_program($sformatf("branch op %0d pair %0d", op, p));
				taken = branch_taken(op, va[p], vb[p]);
				check_word($sformatf("branch op %0d pair %0d fall", op, p),
					taken ? 32'd0 : 32'd1, dmem[0]);
				check_word($sformatf("branch op %0d pair %0d target", op, p),
					taken ? 32'd2 : 32'd0, dmem[1]);
			end
		end
	endtask

	task automatic illegal_stops();
		for (int k = 0; k < 2; k++)
		begin
			clear_mems();
			emit(enc(4'h8, 4'h0, 4'd1, 4'd0, 15'h77));
			if (k == 0)
				emit(enc(4'h8, 4'h0, 4'd2, 4'd0, 15'h5) | 32'd1); // size bit
			else
				emit(enc(4'h5, 4'h0, 4'd2, 4'd0, 15'h0));
			emit(enc(4'ha, 4'h0, 4'd1, 4'd0, 15'd0));
			run_program($sformatf("illegal %0d", k));
			// pc stops just past the illegal word
			check_word($sformatf("illegal %0d stop address", k), 32'd8, ins_req.adr);
			check_word($sformatf("illegal %0d store", k), '0, dmem[0]);
		end
	endtask

	task automatic halt_restart();
		clear_mems();
		emit(enc(4'h8, 4'h0, 4'd1, 4'd0, 15'h11));
		emit(enc(4'ha, 4'h0, 4'd1, 4'd0, 15'd4));
		run_program("restart first");
		check_word("restart first", 32'h11, dmem[1]);
		dmem[1] = '0;
		run_program("restart second");
		check_word("restart second", 32'h11, dmem[1]);
	endtask

	initial
	begin
		clk_i = 1'b0;
		rst_i <= 1'b1;
		ins_rsp <= '0;
		dat_rsp <= '0;
		lfsr = 32'h243fd068;
		errors = 0;
		checks = 0;
		alu_reg_ops();
		imm_load_store();
		branch_table();
		illegal_stops();
		halt_restart();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
